// File: flist.f
+incdir+verif
rtl/vec_pkg.sv
rtl/vaddsub.sv
rtl/vlogic.sv
rtl/vshift.sv
rtl/vtype_cfg.sv
rtl/valu_ctrl.sv
rtl/valu_top.sv
verif/valu_tb.sv

// File: Makefile
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= valu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "make targets:"
	@echo "  test   build the testbench with $(SIM), run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/valu_tb_checks.svh
`ifndef VALU_TB_CHECKS_SVH
`define VALU_TB_CHECKS_SVH

// element width in bits
function automatic int elem_bits(input sew_t s);
    case (s)
        SEW_8:   return 8;
        SEW_16:  return 16;
        SEW_32:  return 32;
        default: return 64;
    endcase
endfunction

// a one in the low bit of every element
function automatic bus64_t elem_ones(input sew_t s);
    bus64_t r;
    r = '0;
    for (int i = 0; i < 64 / elem_bits(s); i++) begin
        r = r | (64'd1 << (i * elem_bits(s)));
    end
    return r;
endfunction

function automatic bus64_t rand64();
    return {$random(seed), $random(seed)};
endfunction

// expected vd built element by element where masked elements keep vs2
function automatic bus64_t ref_op(input instr_type_t o, input sew_t s, input emask_t m,
                                  input bus64_t a1, input bus64_t a2);
    int     w;
    bus64_t lm;        // low w bits set
    bus64_t amt_mask;  // shift amount uses log2(w) bits
    bus64_t x;         // vs2 element
    bus64_t y;         // vs1 element
    bus64_t r;
    bus64_t res;
    w        = elem_bits(s);
    lm       = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    amt_mask = bus64_t'(w - 1);
    res      = '0;
    for (int i = 0; i < 64 / w; i++) begin
        x = (a2 >> (i * w)) & lm;
        y = (a1 >> (i * w)) & lm;
        case (o)
            VADD:    r = x + y;
            VSUB:    r = x - y;
            VRSUB:   r = y - x;
            VAND:    r = x & y;
            VOR:     r = x | y;
            VXOR:    r = x ^ y;
            VSLL:    r = x << (y & amt_mask);
            VSRL:    r = x >> (y & amt_mask);
            default: begin
                if (((x >> (w - 1)) & 64'd1) != 0) x = x | ~lm;   // sign extend
                r = bus64_t'($signed(x) >>> (y & amt_mask));
            end
        endcase
        if (((m >> i) & 8'd1) == 0) r = x;   // upper bits cut by lm below
        res = res | ((r & lm) << (i * w));
    end
    return res;
endfunction

// all ones plus one in the low byte carries up to the first element edge
function automatic sew_t sew_from_carry(input bus64_t res, output logic known);
    known = 1'b1;
    case (res)
        64'hffff_ffff_ffff_ff00: return SEW_8;
        64'hffff_ffff_ffff_0000: return SEW_16;
        64'hffff_ffff_0000_0000: return SEW_32;
        64'h0000_0000_0000_0000: return SEW_64;
        default:                 known = 1'b0;
    endcase
    return SEW_64;
endfunction

// single cycle config strobe issued while idle
task automatic write_cfg(input sew_t s, input emask_t m);
    @(negedge clk);
    cfg_we   = 1'b1;
    cfg_sew  = s;
    cfg_mask = m;
    @(negedge clk);
    cfg_we   = 1'b0;
endtask

// all four phases with the result taken while ack is high
task automatic run_op(input instr_type_t o, input bus64_t a1, input bus64_t a2,
                      output bus64_t res);
    @(negedge clk);
    op  = o;
    vs1 = a1;
    vs2 = a2;
    req = 1'b1;
    wait_ack(1'b1, "after req rose");
    res = vd;
    req = 1'b0;
    wait_ack(1'b0, "after req fell");
endtask

task automatic check_vd(input bus64_t exp, input bus64_t got, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s, expected %h got %h", $time, what, exp, got);
    end
endtask

task automatic check_sew(input sew_t exp, input sew_t got, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s, expected %s got %s", $time, what, exp.name(), got.name());
    end
endtask

task automatic check_ack(input logic exp, input logic got, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s, expected ack %b got %b", $time, what, exp, got);
    end
endtask

task automatic check_carry_width(input bus64_t res, input sew_t exp, input string what);
    sew_t seen;
    logic known;
    seen = sew_from_carry(res, known);
    if (known) begin
        check_sew(exp, seen, what);
    end else begin
        checks++;
        errors++;
        $display("FAILED at %0t: %s, width probe add gave %h which fits no element width",
                 $time, what, res);
    end
endtask

task automatic expect_width(input sew_t exp, input string what);
    bus64_t res;
    run_op(VADD, 64'h1, '1, res);
    check_carry_width(res, exp, what);
endtask

`endif

// File: verif/valu_tb.sv
`timescale 1ns/1ps

module valu_tb;
    import vec_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int ACK_TIMEOUT  = 40;   // cycles allowed per ack edge

    logic        clk;
    logic        rst_n;
    logic        req;
    instr_type_t op;
    bus64_t      vs1;
    bus64_t      vs2;
    logic        cfg_we;
    sew_t        cfg_sew;
    emask_t      cfg_mask;
    logic        ack;
    bus64_t      vd;

    integer      seed;        // $random state
    int          checks;
    int          errors;
    int          tests;
    int          bad_tests;   // tests with at least one mismatch
    sew_t        widths[4]    = '{SEW_8, SEW_16, SEW_32, SEW_64};
    instr_type_t arith_ops[3] = '{VADD, VSUB, VRSUB};
    instr_type_t bit_ops[6]   = '{VAND, VOR, VXOR, VSLL, VSRL, VSRA};
    instr_type_t mask_ops[3]  = '{VRSUB, VOR, VSLL};
    emask_t      mask_pats[4] = '{8'h5a, 8'h06, 8'h01, 8'h00};   // one per width

    valu_top #(.RESET_SEW(SEW_64)) dut (
        .clk_i(clk), .rst_n_i(rst_n),
        .req_i(req), .op_i(op), .vs1_i(vs1), .vs2_i(vs2),
        .cfg_we_i(cfg_we), .cfg_sew_i(cfg_sew), .cfg_mask_i(cfg_mask),
        .ack_o(ack), .vd_o(vd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // polls on falling edges, a stuck handshake ends the run
    task automatic wait_ack(input logic level, input string phase);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level) begin
            $display("timeout: ack_o did not reach %b %s within %0d cycles",
                     level, phase, ACK_TIMEOUT);
            $display("Test failed");
            $finish;
        end
    endtask

    `include "valu_tb_checks.svh"

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%-18s ok", name);
        end else begin
            bad_tests++;
            $display("%-18s %0d mismatches", name, errors - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int     e0;
        bus64_t res;
        e0 = errors;
        @(negedge clk);
        check_ack(1'b0, ack, "ack after reset");
        check_vd('0, vd, "vd after reset");
        run_op(VADD, 64'h1, '1, res);    // one 64 bit element, wraps to zero
        check_vd('0, res, "all ones plus one at reset width");
        expect_width(SEW_64, "reset width");
        finish_test("reset_state", e0);
    endtask

    task automatic test_addsub();
        int     e0;
        bus64_t a1;
        bus64_t a2;
        bus64_t res;
        e0 = errors;
        foreach (widths[k]) begin
            write_cfg(widths[k], 8'hff);
            run_op(VADD, elem_ones(widths[k]), '1, res);   // every element wraps alone
            check_vd('0, res, $sformatf("per element wrap %s", widths[k].name()));
            for (int n = 0; n < 4; n++) begin
                foreach (arith_ops[j]) begin
                    a1 = rand64();
                    a2 = rand64();
                    run_op(arith_ops[j], a1, a2, res);
                    check_vd(ref_op(arith_ops[j], widths[k], 8'hff, a1, a2), res,
                             $sformatf("%s %s", arith_ops[j].name(), widths[k].name()));
                end
            end
        end
        finish_test("add_sub", e0);
    endtask

    task automatic test_logic_shift();
        int     e0;
        bus64_t a1;
        bus64_t a2;
        bus64_t res;
        e0 = errors;
        foreach (widths[k]) begin
            write_cfg(widths[k], 8'hff);
            for (int n = 0; n < 3; n++) begin
                foreach (bit_ops[j]) begin
                    a1 = rand64();
                    a2 = rand64();
                    // every element negative so sra has to fill with ones
                    if (bit_ops[j] == VSRA) begin
                        a2 = a2 | (elem_ones(widths[k]) << (elem_bits(widths[k]) - 1));
                    end
                    run_op(bit_ops[j], a1, a2, res);
                    check_vd(ref_op(bit_ops[j], widths[k], 8'hff, a1, a2), res,
                             $sformatf("%s %s", bit_ops[j].name(), widths[k].name()));
                end
            end
        end
        finish_test("logic_shift", e0);
    endtask

    task automatic test_mask();
        int     e0;
        bus64_t a1;
        bus64_t a2;
        bus64_t res;
        e0 = errors;
        foreach (widths[k]) begin
            write_cfg(widths[k], mask_pats[k]);
            foreach (mask_ops[j]) begin
                a1 = rand64();
                a2 = rand64();
                run_op(mask_ops[j], a1, a2, res);
                check_vd(ref_op(mask_ops[j], widths[k], mask_pats[k], a1, a2), res,
                         $sformatf("masked %s %s", mask_ops[j].name(), widths[k].name()));
                if (mask_pats[k] == 8'h00) check_vd(a2, res, "fully masked gives vs2");
            end
        end
        finish_test("element_mask", e0);
    endtask

    task automatic test_backpressure();
        int     e0;
        bus64_t a1;
        bus64_t a2;
        bus64_t held;
        e0 = errors;
        write_cfg(SEW_16, 8'hff);
        a1 = rand64();
        a2 = rand64();
        @(negedge clk);
        op  = VSUB;
        vs1 = a1;
        vs2 = a2;
        req = 1'b1;
        wait_ack(1'b1, "with req held");
        held = vd;
        check_vd(ref_op(VSUB, SEW_16, 8'hff, a1, a2), held, "VSUB under back-pressure");
        repeat (6) begin    // unit parks in DONE
            @(negedge clk);
            check_ack(1'b1, ack, "ack while req held");
            check_vd(held, vd, "vd while req held");
        end
        req = 1'b0;
        @(negedge clk);
        check_ack(1'b0, ack, "ack one edge after req fell");
        wait_ack(1'b0, "after req fell");
        finish_test("backpressure", e0);
    endtask

    task automatic test_cfg_while_busy();
        int e0;
        e0 = errors;
        write_cfg(SEW_16, 8'hff);
        @(negedge clk);
        op  = VADD;
        vs1 = 64'h1;
        vs2 = '1;
        req = 1'b1;
        @(negedge clk);            // req sampled, unit in EXEC
        cfg_we   = 1'b1;
        cfg_sew  = SEW_8;
        cfg_mask = 8'h00;          // would pass vs2 through if it landed
        @(negedge clk);
        cfg_we   = 1'b0;
        wait_ack(1'b1, "with a config write pending");
        check_carry_width(vd, SEW_16, "width of the op in flight");
        req = 1'b0;
        wait_ack(1'b0, "after req fell");
        expect_width(SEW_16, "width after dropped write");
        write_cfg(SEW_8, 8'hff);   // same write while idle does land
        expect_width(SEW_8, "width after idle write");
        finish_test("cfg_while_busy", e0);
    endtask

    initial begin
        seed      = 32'h7ec9;
        rst_n     = 1'b0;
        req       = 1'b0;
        op        = VADD;
        vs1       = '0;
        vs2       = '0;
        cfg_we    = 1'b0;
        cfg_sew   = SEW_64;
        cfg_mask  = '1;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        bad_tests = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_addsub();
        test_logic_shift();
        test_mask();
        test_backpressure();
        test_cfg_while_busy();
        $display("%0d tests, %0d with mismatches, %0d checks, %0d errors",
                 tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rtl/valu_top.sv
`timescale 1ns/1ps

module valu_top #(
    parameter vec_pkg::sew_t RESET_SEW = vec_pkg::SEW_64
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  vec_pkg::instr_type_t op_i,
    input  vec_pkg::bus64_t      vs1_i,
    input  vec_pkg::bus64_t      vs2_i,
    input  logic                 cfg_we_i,
    input  vec_pkg::sew_t        cfg_sew_i,
    input  vec_pkg::emask_t      cfg_mask_i,
    output logic                 ack_o,
    output vec_pkg::bus64_t      vd_o
);
    import vec_pkg::*;

    instr_type_t op_w;          // latched op to the datapaths
    bus64_t      vs1_w;
    bus64_t      vs2_w;
    sew_t        sew_w;
    emask_t      mask_w;
    logic        busy_w;
    bus64_t      addsub_res_w;
    bus64_t      logic_res_w;
    bus64_t      shift_res_w;

    valu_ctrl u_ctrl (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_i(req_i), .op_i(op_i), .vs1_i(vs1_i), .vs2_i(vs2_i),
        .sew_i(sew_w), .mask_i(mask_w),
        .addsub_res_i(addsub_res_w), .logic_res_i(logic_res_w), .shift_res_i(shift_res_w),
        .op_o(op_w), .vs1_o(vs1_w), .vs2_o(vs2_w),
        .busy_o(busy_w), .ack_o(ack_o), .vd_o(vd_o)
    );

    vtype_cfg #(.RESET_SEW(RESET_SEW)) u_cfg (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .cfg_we_i(cfg_we_i), .cfg_sew_i(cfg_sew_i), .cfg_mask_i(cfg_mask_i),
        .busy_i(busy_w), .sew_o(sew_w), .mask_o(mask_w)
    );

    vaddsub u_addsub (
        .instr_type_i(op_w), .sew_i(sew_w),
        .data_vs1_i(vs1_w), .data_vs2_i(vs2_w), .data_vd_o(addsub_res_w)
    );

    vlogic u_logic (
        .instr_type_i(op_w),
        .data_vs1_i(vs1_w), .data_vs2_i(vs2_w), .data_vd_o(logic_res_w)
    );

    vshift u_shift (
        .instr_type_i(op_w), .sew_i(sew_w),
        .data_vs1_i(vs1_w), .data_vs2_i(vs2_w), .data_vd_o(shift_res_w)
    );

endmodule

// File: rtl/valu_ctrl.sv
`timescale 1ns/1ps

module valu_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,           // four phase request
    input  vec_pkg::instr_type_t op_i,
    input  vec_pkg::bus64_t      vs1_i,
    input  vec_pkg::bus64_t      vs2_i,
    input  vec_pkg::sew_t        sew_i,           // from vtype_cfg
    input  vec_pkg::emask_t      mask_i,          // from vtype_cfg
    input  vec_pkg::bus64_t      addsub_res_i,
    input  vec_pkg::bus64_t      logic_res_i,
    input  vec_pkg::bus64_t      shift_res_i,
    output vec_pkg::instr_type_t op_o,            // latched op to the datapaths
    output vec_pkg::bus64_t      vs1_o,
    output vec_pkg::bus64_t      vs2_o,
    output logic                 busy_o,          // blocks config writes
    output logic                 ack_o,
    output vec_pkg::bus64_t      vd_o             // valid while ack_o is high
);
    import vec_pkg::*;

    ctrl_state_t state_q;
    instr_type_t op_q;
    bus64_t      vs1_q;
    bus64_t      vs2_q;
    logic        ack_q;
    bus64_t      vd_q;
    bus64_t      sel_res;     // datapath result picked by opcode class
    logic [7:0]  byte_en;     // mask bit of the element each byte belongs to
    bus64_t      merged;

    always_comb begin
        case (op_q)
            VADD, VSUB, VRSUB: sel_res = addsub_res_i;
            VAND, VOR, VXOR:   sel_res = logic_res_i;
            VSLL, VSRL, VSRA:  sel_res = shift_res_i;
            default:           sel_res = addsub_res_i;
        endcase
    end

    // byte b sits in element b / (width in bytes)
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            case (sew_i)
                SEW_8:   byte_en[b] = mask_i[b];
                SEW_16:  byte_en[b] = mask_i[b >> 1];
                SEW_32:  byte_en[b] = mask_i[b >> 2];
                default: byte_en[b] = mask_i[0];
            endcase
            // inactive elements keep vs2
            merged[8*b +: 8] = byte_en[b] ? sel_res[8*b +: 8] : vs2_q[8*b +: 8];
        end
    end

    // operands captured on the edge that accepts req
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i) begin
            op_q  <= op_i;
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
            vd_q    <= '0;
        end else begin
            case (state_q)
                IDLE: if (req_i) state_q <= EXEC;
                EXEC: begin
                    vd_q    <= merged;    // result and ack one edge after the latch
                    ack_q   <= 1'b1;
                    state_q <= DONE;
                end
                DONE: if (!req_i) begin   // held here while requester keeps req high
                    ack_q   <= 1'b0;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign op_o   = op_q;
    assign vs1_o  = vs1_q;
    assign vs2_o  = vs2_q;
    assign busy_o = (state_q != IDLE);
    assign ack_o  = ack_q;
    assign vd_o   = vd_q;

    // ack rises two edges after req is first sampled and req is high on both
    ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> ($past(req_i) && $past(req_i, 2))
    );

    // req may only drop once the requester has seen ack
    req_held_until_ack: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $fell(req_i) |-> ack_o
    );

endmodule

// File: rtl/vtype_cfg.sv
`timescale 1ns/1ps

module vtype_cfg #(
    parameter vec_pkg::sew_t RESET_SEW = vec_pkg::SEW_64   // width after reset
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            cfg_we_i,     // single cycle write strobe
    input  vec_pkg::sew_t   cfg_sew_i,    // new element width
    input  vec_pkg::emask_t cfg_mask_i,   // new element mask
    input  logic            busy_i,       // controller is running an operation
    output vec_pkg::sew_t   sew_o,
    output vec_pkg::emask_t mask_o
);
    import vec_pkg::*;

    sew_t   sew_q;
    emask_t mask_q;
    logic   wr_ok;    // write accepted this cycle

    // writes during an operation are dropped, not queued
    assign wr_ok = cfg_we_i && !busy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sew_q  <= RESET_SEW;
            mask_q <= '1;             // all elements active
        end else if (wr_ok) begin
            sew_q  <= cfg_sew_i;
            mask_q <= cfg_mask_i;
        end
    end

    assign sew_o  = sew_q;
    assign mask_o = mask_q;

    // the datapaths read the config throughout EXEC and DONE,
    // it has to hold still until the controller is idle again
    cfg_stable_while_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        busy_i |=> ($stable(sew_o) && $stable(mask_o))
    );

endmodule

// File: rtl/vshift.sv
`timescale 1ns/1ps

module vshift (
    input  vec_pkg::instr_type_t instr_type_i,   // sll, srl or sra
    input  vec_pkg::sew_t        sew_i,          // element width
    input  vec_pkg::bus64_t      data_vs1_i,     // shift amounts, one per element
    input  vec_pkg::bus64_t      data_vs2_i,     // data to shift
    output vec_pkg::bus64_t      data_vd_o       // shifted elements
);
    import vec_pkg::*;

    bus64_t ext;       // current element widened to 64 bits
    bus64_t shifted;   // widened element after the shift

    // shift on a widened element, only the low element bits are kept
    // afterwards, so sign fill for sra comes from the extension
    function automatic bus64_t shift_one(instr_type_t op, bus64_t val, logic [5:0] amt);
        case (op)
            VSLL:    shift_one = val << amt;
            VSRA:    shift_one = bus64_t'($signed(val) >>> amt);
            default: shift_one = val >> amt;
        endcase
    endfunction

    always_comb begin
        data_vd_o = '0;
        ext       = '0;
        shifted   = '0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    ext = (instr_type_i == VSRA) ? {{56{data_vs2_i[8*i+7]}}, data_vs2_i[8*i +: 8]}
                                                 : {56'b0, data_vs2_i[8*i +: 8]};
                    shifted = shift_one(instr_type_i, ext, {3'b0, data_vs1_i[8*i +: 3]});
                    data_vd_o[8*i +: 8] = shifted[7:0];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    ext = (instr_type_i == VSRA) ? {{48{data_vs2_i[16*i+15]}}, data_vs2_i[16*i +: 16]}
                                                 : {48'b0, data_vs2_i[16*i +: 16]};
                    shifted = shift_one(instr_type_i, ext, {2'b0, data_vs1_i[16*i +: 4]});
                    data_vd_o[16*i +: 16] = shifted[15:0];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    ext = (instr_type_i == VSRA) ? {{32{data_vs2_i[32*i+31]}}, data_vs2_i[32*i +: 32]}
                                                 : {32'b0, data_vs2_i[32*i +: 32]};
                    shifted = shift_one(instr_type_i, ext, {1'b0, data_vs1_i[32*i +: 5]});
                    data_vd_o[32*i +: 32] = shifted[31:0];
                end
            end
            default: begin
                // 64 bit, the element already fills the word
                ext       = data_vs2_i;
                shifted   = shift_one(instr_type_i, ext, data_vs1_i[5:0]);
                data_vd_o = shifted;
            end
        endcase
    end

endmodule

// File: rtl/vlogic.sv
`timescale 1ns/1ps

module vlogic (
    input  vec_pkg::instr_type_t instr_type_i,   // and, or or xor
    input  vec_pkg::bus64_t      data_vs1_i,     // source operand 1
    input  vec_pkg::bus64_t      data_vs2_i,     // source operand 2
    output vec_pkg::bus64_t      data_vd_o       // bitwise result
);
    import vec_pkg::*;

    // bitwise ops have no element boundaries, so the width is not needed

    bus64_t and_res;
    bus64_t or_res;
    bus64_t xor_res;

    assign and_res = data_vs2_i & data_vs1_i;
    assign or_res  = data_vs2_i | data_vs1_i;
    assign xor_res = data_vs2_i ^ data_vs1_i;

    always_comb begin
        case (instr_type_i)
            VAND:    data_vd_o = and_res;
            VOR:     data_vd_o = or_res;
            VXOR:    data_vd_o = xor_res;
            default: data_vd_o = and_res;   // not selected by the controller
        endcase
    end

endmodule

// File: rtl/vaddsub.sv
`timescale 1ns/1ps

module vaddsub (
    input  vec_pkg::instr_type_t instr_type_i,   // add, sub or reverse sub
    input  vec_pkg::sew_t        sew_i,          // element width
    input  vec_pkg::bus64_t      data_vs1_i,     // source operand 1
    input  vec_pkg::bus64_t      data_vs2_i,     // source operand 2
    output vec_pkg::bus64_t      data_vd_o       // packed result
);
    import vec_pkg::*;

    // eight byte adders; the element width decides whether a byte
    // takes the carry of the byte below it or starts a new element

    logic            is_sub;      // sub or rsub, carry in of one per element
    bus64_t          opa;         // vs2 side, inverted for rsub
    bus64_t          opb;         // vs1 side, inverted for sub
    logic [7:0]      chain;       // byte i continues the element of byte i-1
    logic [7:0]      carry_in;    // carry into each byte adder
    logic [7:0][8:0] byte_sum;    // byte result plus carry out
    logic            carry;       // carry out of the previous byte

    // operand conditioning, two's complement by invert plus one
    always_comb begin
        is_sub = (instr_type_i == VSUB) || (instr_type_i == VRSUB);
        opa    = (instr_type_i == VRSUB) ? ~data_vs2_i : data_vs2_i;
        opb    = (instr_type_i == VSUB)  ? ~data_vs1_i : data_vs1_i;
    end

    // carry chaining per byte
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (sew_i)
                SEW_8:   chain[i] = 1'b0;              // every byte is its own element
                SEW_16:  chain[i] = (i % 2) != 0;      // odd bytes are upper halves
                SEW_32:  chain[i] = (i % 4) != 0;
                default: chain[i] = (i != 0);          // 64 bit, one long chain
            endcase
        end
    end

    // ripple through the byte adders
    always_comb begin
        carry = 1'b0;
        for (int i = 0; i < 8; i++) begin
            // low byte of an element gets the sub carry, others the chain
            carry_in[i] = chain[i] ? carry : is_sub;
            byte_sum[i] = {1'b0, opa[8*i +: 8]} + {1'b0, opb[8*i +: 8]}
                        + {8'b0, carry_in[i]};
            carry       = byte_sum[i][8];
        end
    end

    // drop the carry bits, pack the bytes back
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            data_vd_o[8*i +: 8] = byte_sum[i][7:0];
        end
    end

endmodule

// File: rtl/vec_pkg.sv
package vec_pkg;

    // one full vector register, 8 to 64 bit elements packed inside
    typedef logic [63:0] bus64_t;

    // element width, values match the usual vsew field encoding
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,   // eight byte elements
        SEW_16 = 2'b01,   // four halfword elements
        SEW_32 = 2'b10,   // two word elements
        SEW_64 = 2'b11    // one doubleword element
    } sew_t;

    // operations the unit can run, one per request
    typedef enum logic [3:0] {
        VADD  = 4'd0,     // vs2 + vs1
        VSUB  = 4'd1,     // vs2 - vs1
        VRSUB = 4'd2,     // vs1 - vs2
        VAND  = 4'd3,
        VOR   = 4'd4,
        VXOR  = 4'd5,
        VSLL  = 4'd6,     // shift left
        VSRL  = 4'd7,     // logical shift right
        VSRA  = 4'd8      // arithmetic shift right, sign fill
    } instr_type_t;

    // one bit per element, bit i enables element i
    // with wide elements only the low bits matter
    typedef logic [7:0] emask_t;

    // handshake controller states
    typedef enum logic [1:0] {
        IDLE = 2'b00,     // waiting for req
        EXEC = 2'b01,     // operands latched, datapaths settling
        DONE = 2'b10      // ack high, waiting for req to drop
    } ctrl_state_t;

endpackage
